// File: logic/dds_pkg.sv
package dds_pkg;

   //////////////////////////////
   // datapath types
   //////////////////////////////
   typedef logic [31:0] phase_t;     // accumulator and tuning word
   typedef logic [11:0] sample_t;    // two's complement
   typedef logic [31:0] apb_data_t;

   // square wave levels, full scale
   localparam sample_t SQUARE_HI = 12'h7FF;
   localparam sample_t SQUARE_LO = 12'h800;

   typedef enum logic [1:0] {
      wave_square = 2'd0,
      wave_saw    = 2'd1
   } wave_e;

   typedef enum logic [1:0] {
      mod_none = 2'd0,
      mod_ask  = 2'd1,   // on/off keying from the lfsr
      mod_bpsk = 2'd2    // sign flip from the lfsr
   } mod_e;

   //////////////////////////////
   // register map, byte addresses
   //////////////////////////////
   typedef enum logic [7:0] {
      reg_wave      = 8'h00,
      reg_mod       = 8'h04,
      reg_phase_inc = 8'h08,
      reg_keys      = 8'h0C    // read only
   } reg_addr_e;

endpackage

// File: logic/kbd_pkg.sv
package kbd_pkg;

   localparam int KEY_COUNT = 13;

   // id 0 is unused, held set bit i is id i+1
   typedef enum logic [6:0] {
      key_1     = 7'd1,
      key_2     = 7'd2,
      key_3     = 7'd3,
      key_4     = 7'd4,
      key_f1    = 7'd5,
      key_f2    = 7'd6,
      key_n     = 7'd7,
      key_m     = 7'd8,
      key_space = 7'd9,
      key_left  = 7'd10,
      key_right = 7'd11,
      key_up    = 7'd12,
      key_down  = 7'd13
   } kbd_key_e;

   typedef struct packed {
      logic     brk;   // 1 = release, 0 = press
      kbd_key_e key;
   } kbd_event_t;

   typedef logic [KEY_COUNT-1:0] keys_t;

endpackage

// File: logic/key_tracker.sv
`timescale 1ns/1ps

module key_tracker
   import kbd_pkg::*;
(
   input  logic       CLK_25MHZ,
   input  logic       reset_from_key,
   input  logic       kbd_valid,
   input  kbd_event_t kbd_event,
   output keys_t      held_keys
);

   keys_t held_q;
   keys_t hit;     // one-hot match of the event id

   //////////////////////////////
   // id decode
   //////////////////////////////
   // ids outside 1..KEY_COUNT match nothing and fall through
   always_comb
   begin
      hit = '0;
      for (int i = 0; i < KEY_COUNT; i++)
      begin
         if (kbd_event.key == kbd_key_e'(i + 1))
            hit[i] = 1'b1;
      end
   end

   //////////////////////////////
   // held state
   //////////////////////////////
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         held_q <= '0;
      end
      else if (kbd_valid)
      begin
         if (kbd_event.brk)
            held_q <= held_q & ~hit;   // break clears
         else
            held_q <= held_q | hit;    // make sets
      end
   end

   assign held_keys = held_q;

endmodule

// File: logic/apb_regs.sv
`timescale 1ns/1ps

module apb_regs
   import dds_pkg::*;
   import kbd_pkg::*;
#(
   parameter phase_t DEFAULT_PHASE_INC = 32'd258
)
(
   input  logic      CLK_25MHZ,
   input  logic      reset_from_key,
   input  logic [7:0] paddr,
   input  logic      psel,
   input  logic      penable,
   input  logic      pwrite,
   input  apb_data_t pwdata,
   output apb_data_t prdata,
   output logic      pready,
   output logic      pslverr,
   input  keys_t     held_keys,
   output wave_e     wave_sel,
   output mod_e      mod_sel,
   output phase_t    phase_inc
);

   reg_addr_e addr;
   logic      access;     // apb access phase
   logic      mapped;
   logic      wr_en;

   assign addr   = reg_addr_e'(paddr);
   assign access = psel & penable;
   assign pready = 1'b1;   // zero wait states

   always_comb
   begin
      case (addr)
         reg_wave, reg_mod, reg_phase_inc, reg_keys: mapped = 1'b1;
         default:                                    mapped = 1'b0;
      endcase
   end

   // key readback cannot be written
   assign pslverr = access & (~mapped | (pwrite & (addr == reg_keys)));
   assign wr_en   = access & pwrite & ~pslverr;

   //////////////////////////////
   // control registers
   //////////////////////////////
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         wave_sel  <= wave_square;
         mod_sel   <= mod_none;
         phase_inc <= DEFAULT_PHASE_INC;
      end
      else if (wr_en)
      begin
         case (addr)
            reg_wave:      wave_sel  <= wave_e'(pwdata[1:0]);
            reg_mod:       mod_sel   <= mod_e'(pwdata[1:0]);   // 3 kept, acts as none
            reg_phase_inc: phase_inc <= pwdata;
            default:       ;
         endcase
      end
   end

   //////////////////////////////
   // read mux
   //////////////////////////////
   always_comb
   begin
      prdata = '0;
      if (psel && !pwrite)
      begin
         case (addr)
            reg_wave:      prdata = apb_data_t'(wave_sel);
            reg_mod:       prdata = apb_data_t'(mod_sel);
            reg_phase_inc: prdata = phase_inc;
            reg_keys:      prdata = apb_data_t'(held_keys);   // upper bits zero
            default:       prdata = '0;
         endcase
      end
   end

endmodule

// File: logic/lfsr_gen.sv
`timescale 1ns/1ps

module lfsr_gen #(
   parameter int unsigned LFSR_DIV = 8
)
(
   input  logic CLK_25MHZ,
   input  logic reset_from_key,
   output logic lfsr_bit
);

   localparam int CNT_W = (LFSR_DIV > 1) ? $clog2(LFSR_DIV) : 1;

   logic [CNT_W-1:0] div_cnt;
   logic             step;     // one-cycle enable
   logic [4:0]       state;

   assign step = (div_cnt == CNT_W'(LFSR_DIV - 1));

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         div_cnt <= '0;
         state   <= 5'b00001;   // any nonzero seed
      end
      else
      begin
         div_cnt <= step ? '0 : div_cnt + 1'b1;
         if (step)
            state <= {state[0] ^ state[2], state[4:1]};   // x^5 + x^3 + 1, period 31
      end
   end

   assign lfsr_bit = state[0];

endmodule

// File: logic/dds_core.sv
`timescale 1ns/1ps

module dds_core
   import dds_pkg::*;
(
   input  logic    CLK_25MHZ,
   input  logic    reset_from_key,
   input  wave_e   wave_sel,
   input  mod_e    mod_sel,
   input  phase_t  phase_inc,
   input  logic    lfsr_bit,
   output sample_t orig_sample,
   output sample_t mod_sample
);

   phase_t  phase;
   sample_t shaped;      // waveform from the current phase
   sample_t modulated;

   //////////////////////////////
   // phase accumulator
   //////////////////////////////
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         phase <= '0;
      else
         phase <= phase + phase_inc;   // wraps mod 2^32
   end

   //////////////////////////////
   // waveform shaping
   //////////////////////////////
   always_comb
   begin
      case (wave_sel)
         wave_saw: shaped = {~phase[31], phase[30:20]};   // offset binary to signed
         default:  shaped = phase[31] ? SQUARE_LO : SQUARE_HI;
      endcase
   end

   // modulation from the lfsr
   always_comb
   begin
      case (mod_sel)
         mod_ask:  modulated = lfsr_bit ? shaped : '0;
         mod_bpsk: modulated = lfsr_bit ? shaped : ~shaped;
         default:  modulated = shaped;   // none, and the unused code 3
      endcase
   end

   //////////////////////////////
   // output registers
   //////////////////////////////
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         orig_sample <= '0;
         mod_sample  <= '0;
      end
      else
      begin
         orig_sample <= shaped;
         mod_sample  <= modulated;
      end
   end

endmodule

// File: logic/synth_top.sv
`timescale 1ns/1ps

module synth_top
   import dds_pkg::*;
   import kbd_pkg::*;
#(
   parameter phase_t      DEFAULT_PHASE_INC = 32'd258,
   parameter int unsigned LFSR_DIV          = 8
)
(
   input  logic       CLK_25MHZ,
   input  logic       reset_from_key,
   // apb slave
   input  logic [7:0] paddr,
   input  logic       psel,
   input  logic       penable,
   input  logic       pwrite,
   input  apb_data_t  pwdata,
   output apb_data_t  prdata,
   output logic       pready,
   output logic       pslverr,
   // decoded keyboard events
   input  logic       kbd_valid,
   input  kbd_event_t kbd_event,
   // synth outputs
   output sample_t    orig_sample,
   output sample_t    mod_sample,
   output logic       lfsr_bit
);

   keys_t  held_keys;
   wave_e  wave_sel;
   mod_e   mod_sel;
   phase_t phase_inc;

   key_tracker key_tracker_i (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .kbd_valid      (kbd_valid),
      .kbd_event      (kbd_event),
      .held_keys      (held_keys)
   );

   apb_regs #(
      .DEFAULT_PHASE_INC (DEFAULT_PHASE_INC)
   ) apb_regs_i (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .paddr          (paddr),
      .psel           (psel),
      .penable        (penable),
      .pwrite         (pwrite),
      .pwdata         (pwdata),
      .prdata         (prdata),
      .pready         (pready),
      .pslverr        (pslverr),
      .held_keys      (held_keys),
      .wave_sel       (wave_sel),
      .mod_sel        (mod_sel),
      .phase_inc      (phase_inc)
   );

   lfsr_gen #(
      .LFSR_DIV (LFSR_DIV)
   ) lfsr_gen_i (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .lfsr_bit       (lfsr_bit)
   );

   dds_core dds_core_i (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .wave_sel       (wave_sel),
      .mod_sel        (mod_sel),
      .phase_inc      (phase_inc),
      .lfsr_bit       (lfsr_bit),
      .orig_sample    (orig_sample),
      .mod_sample     (mod_sample)
   );

endmodule

// File: dv/synth_sva.sv
`timescale 1ns/1ps

module synth_sva
   import dds_pkg::*;
(
   input logic    CLK_25MHZ,
   input logic    reset_from_key,
   input logic    psel,
   input logic    penable,
   input logic    pready,
   input logic    pslverr,
   input mod_e    mod_sel,
   input logic    lfsr_bit,
   input sample_t mod_sample
);

   pslverr_in_access: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      pslverr |-> (psel && penable))
      else $error("pslverr high outside an access phase");

   pready_high: assert property (@(posedge CLK_25MHZ) pready === 1'b1)
      else $error("pready dropped");

   // ask keys the output off while the lfsr bit is low
   ask_gates_off: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      (mod_sel == mod_ask && !lfsr_bit) |=> (mod_sample == '0))
      else $error("mod_sample not zero under ask with lfsr_bit low");

endmodule

bind synth_top synth_sva sva_i (
   .CLK_25MHZ      (CLK_25MHZ),
   .reset_from_key (reset_from_key),
   .psel           (psel),
   .penable        (penable),
   .pready         (pready),
   .pslverr        (pslverr),
   .mod_sel        (mod_sel),
   .lfsr_bit       (lfsr_bit),
   .mod_sample     (mod_sample)
);

// File: dv/synth_tb.sv
`timescale 1ns/1ps

module synth_tb
   import dds_pkg::*;
   import kbd_pkg::*;
();

   localparam phase_t      DEFAULT_PHASE_INC = 32'd258;
   localparam int unsigned LFSR_DIV          = 8;
   // regs 216, keys 560, saw 60, square 210, lfsr 330, modulation 240
   localparam int          TOTAL_CYCLES      = 216 + 560 + 60 + 210 + 330 + 240;
   localparam longint      WATCHDOG_NS       = 2 * TOTAL_CYCLES * 40;

   logic       CLK_25MHZ = 1'b0;
   logic       reset_from_key;
   logic [7:0] paddr;
   logic       psel;
   logic       penable;
   logic       pwrite;
   apb_data_t  pwdata;
   apb_data_t  prdata;
   logic       pready;
   logic       pslverr;
   logic       kbd_valid;
   kbd_event_t kbd_event;
   sample_t    orig_sample;
   sample_t    mod_sample;
   logic       lfsr_bit;

   logic [31:0] rng_state = 32'he2805352;
   int          error_count = 0;
   apb_data_t   reg_model [3];   // wave, mod, phase_inc
   keys_t       key_model;

   synth_top #(
      .DEFAULT_PHASE_INC (DEFAULT_PHASE_INC),
      .LFSR_DIV          (LFSR_DIV)
   ) dut_i (.*);

   always #20 CLK_25MHZ = ~CLK_25MHZ;   // 25 MHz

   //////////////////////////////
   // reporting and compare
   //////////////////////////////
   task automatic fail_run(input string msg);
      error_count++;
      $display("%s", msg);
      $display("SOME TESTS FAILED");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_data(input string name, input apb_data_t got, input apb_data_t exp);
      if (got !== exp)
         fail_run($sformatf("ERR %s got %h expected %h", name, got, exp));
   endtask

   task automatic check_keys(input string name, input keys_t got, input keys_t exp);
      if (got !== exp)
         fail_run($sformatf("ERR %s got %h expected %h", name, got, exp));
   endtask

   task automatic check_sample(input string name, input sample_t got, input sample_t exp);
      if (got !== exp)
         fail_run($sformatf("ERR %s got %h expected %h", name, got, exp));
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
         fail_run($sformatf("ERR %s got %h expected %h", name, got, exp));
   endtask

   //////////////////////////////
   // random source
   //////////////////////////////
   function automatic logic [31:0] galois_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);   // x^32+x^22+x^2+x+1
   endfunction

   task automatic draw_bits(input int n, output logic [31:0] r);
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         rng_state = galois_step(rng_state);
         r = {r[30:0], rng_state[0]};
      end
   endtask

   // independent model of the 5-bit lfsr step
   function automatic logic [4:0] lfsr5_next(input logic [4:0] s);
      return {s[0] ^ s[2], s[4:1]};
   endfunction

   function automatic reg_addr_e ctrl_addr(input int idx);
      case (idx)
         0:       return reg_wave;
         1:       return reg_mod;
         default: return reg_phase_inc;
      endcase
   endfunction

   //////////////////////////////
   // bus and reset drivers
   //////////////////////////////
   task automatic do_reset();
      @(posedge CLK_25MHZ);
      reset_from_key <= 1'b1;
      repeat (3) @(posedge CLK_25MHZ);
      reset_from_key <= 1'b0;
      reg_model = '{apb_data_t'(wave_square), apb_data_t'(mod_none), DEFAULT_PHASE_INC};
      key_model = '0;
   endtask

   task automatic apb_write(input logic [7:0] addr, input apb_data_t data, input logic exp_err);
      @(posedge CLK_25MHZ);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b1;
      paddr   <= addr;
      pwdata  <= data;
      @(posedge CLK_25MHZ);
      penable <= 1'b1;
      @(negedge CLK_25MHZ);
      check_bit("pslverr", pslverr, exp_err);
      check_bit("pready", pready, 1'b1);
      @(posedge CLK_25MHZ);   // write edge
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic apb_read(input logic [7:0] addr, input logic exp_err, output apb_data_t data);
      @(posedge CLK_25MHZ);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      paddr   <= addr;
      @(posedge CLK_25MHZ);
      penable <= 1'b1;
      @(negedge CLK_25MHZ);
      data = prdata;   // combinational in access phase
      check_bit("pslverr", pslverr, exp_err);
      check_bit("pready", pready, 1'b1);
      @(posedge CLK_25MHZ);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic check_regs();
      apb_data_t rd;
      apb_read(reg_wave, 1'b0, rd);
      check_data("prdata(reg_wave)", rd, reg_model[0]);
      apb_read(reg_mod, 1'b0, rd);
      check_data("prdata(reg_mod)", rd, reg_model[1]);
      apb_read(reg_phase_inc, 1'b0, rd);
      check_data("prdata(reg_phase_inc)", rd, reg_model[2]);
      apb_read(reg_keys, 1'b0, rd);
      check_keys("held_keys", keys_t'(rd[12:0]), key_model);
      check_data("prdata(reg_keys) upper bits", rd >> 13, '0);
   endtask

   // ends on a falling edge with the new mode settled
   task automatic set_mode(input wave_e w, input logic [1:0] m, input phase_t inc);
      apb_write(reg_wave, apb_data_t'(w), 1'b0);
      apb_write(reg_mod, apb_data_t'(m), 1'b0);
      apb_write(reg_phase_inc, inc, 1'b0);
      reg_model = '{apb_data_t'(w), apb_data_t'(m), inc};
      repeat (3) @(posedge CLK_25MHZ);
      @(negedge CLK_25MHZ);
   endtask

   //////////////////////////////
   // directed tests
   //////////////////////////////
   task automatic test_registers();
      logic [31:0] sel;
      logic [31:0] d;
      apb_data_t   rd;
      int          idx;
      check_regs();   // reset values
      for (int i = 0; i < 12; i++)
      begin
         draw_bits(2, sel);
         draw_bits(32, d);
         idx = int'(sel[1:0]) % 3;
         apb_write(ctrl_addr(idx), d, 1'b0);
         reg_model[idx] = (idx == 2) ? d : (d & 32'h3);   // wave and mod keep 2 bits
         check_regs();
      end
      draw_bits(32, d);
      apb_write(reg_keys, d, 1'b1);
      apb_write(8'h10, d, 1'b1);
      apb_write(8'h06, d, 1'b1);
      apb_read(8'h40, 1'b1, rd);
      check_regs();   // nothing moved
   endtask

   task automatic test_keys();
      logic [31:0] r;
      int          id;
      for (int i = 0; i < 40; i++)
      begin
         draw_bits(5, r);
         id = int'(r[3:0]);   // 0, 14 and 15 are bad ids
         @(posedge CLK_25MHZ);
         kbd_valid <= 1'b1;
         kbd_event <= kbd_event_t'({r[4], 7'(id)});
         @(posedge CLK_25MHZ);
         kbd_valid <= 1'b0;
         if (id >= 1 && id <= 13)
            key_model[id-1] = ~r[4];
         check_regs();
      end
   endtask

   task automatic test_saw();
      logic [31:0] r;
      sample_t     k;
      sample_t     expect_s;
      draw_bits(12, r);
      k = sample_t'(r[11:0]) | 12'd1;   // never a zero step
      set_mode(wave_saw, 2'd0, {k, 20'd0});
      expect_s = orig_sample;
      for (int i = 0; i < 40; i++)
      begin
         @(negedge CLK_25MHZ);
         expect_s = expect_s + k;   // wraps mod 4096
         check_sample("orig_sample", orig_sample, expect_s);
         check_sample("mod_sample", mod_sample, expect_s);
      end
   endtask

   task automatic test_square();
      sample_t prev;
      int      run;
      int      toggles;
      set_mode(wave_square, 2'd0, 32'h0400_0000);
      prev    = orig_sample;
      run     = 0;
      toggles = 0;
      for (int c = 0; c < 5 * 32 + 33; c++)
      begin
         @(negedge CLK_25MHZ);
         if (orig_sample !== 12'h7FF && orig_sample !== 12'h800)
            fail_run($sformatf("ERR orig_sample %h is not a square level", orig_sample));
         run++;
         if (orig_sample != prev)
         begin
            if (toggles > 0)   // first run is partial
               check_data("square half period", apb_data_t'(run), 32'd32);
            toggles++;
            run = 0;
         end
         prev = orig_sample;
      end
      if (toggles < 5)
         fail_run("square output stopped toggling");
   endtask

   task automatic test_lfsr();
      logic [4:0] model;
      do_reset();
      model = 5'b00001;
      for (int c = 0; c <= 40 * LFSR_DIV; c++)
      begin
         @(negedge CLK_25MHZ);
         if (c > 0 && c % LFSR_DIV == 0)
            model = lfsr5_next(model);
         check_bit("lfsr_bit", lfsr_bit, model[0]);
      end
   endtask

   task automatic test_modulation();
      logic [1:0] m;
      logic       bit_before;
      sample_t    expect_s;
      for (int mode = 1; mode <= 3; mode++)   // ask, bpsk, unused code
      begin
         m = 2'(mode);
         set_mode(wave_saw, m, 32'h0130_0000);
         for (int i = 0; i < 64; i++)
         begin
            bit_before = lfsr_bit;
            @(negedge CLK_25MHZ);
            if (bit_before || m == 2'd3)
               expect_s = orig_sample;
            else if (m == 2'd1)
               expect_s = '0;
            else
               expect_s = ~orig_sample;
            check_sample("mod_sample", mod_sample, expect_s);
         end
      end
   endtask

   //////////////////////////////
   // main flow and watchdog
   //////////////////////////////
   initial
   begin
      reset_from_key = 1'b0;
      paddr          = '0;
      psel           = 1'b0;
      penable        = 1'b0;
      pwrite         = 1'b0;
      pwdata         = '0;
      kbd_valid      = 1'b0;
      kbd_event      = '0;
      do_reset();
      test_registers();
      test_keys();
      test_saw();
      test_square();
      test_lfsr();
      test_modulation();
      if (error_count == 0)
      begin
         $display("ALL TESTS PASSED");
         $finish;
      end
      else
         fail_run("errors were counted without stopping the run");
   end

   initial
   begin
      #(WATCHDOG_NS);
      fail_run("watchdog timeout, the tests did not finish in time");
   end

endmodule

// File: build.f
logic/dds_pkg.sv
logic/kbd_pkg.sv
logic/key_tracker.sv
logic/apb_regs.sv
logic/lfsr_gen.sv
logic/dds_core.sv
logic/synth_top.sv
dv/synth_sva.sv
dv/synth_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the synth testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module synth_tb -f build.f --Mdir obj_dir -o synth_tb_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/synth_tb_sim
status=$?
if [ $status -ne 0 ]; then
   echo "simulation failed with status $status"
fi
exit $status
